/* flist.f */
+incdir+.
dcore_pkg.sv
wb_intercon.sv
glbl_cfg.sv
pad_ctrl.sv
digital_core.sv
tb_clkgen.sv
digital_core_sva.sv
digital_core_tb.sv

/* digital_core_tb.sv */
// Testbench for the digital core with random register traffic and a shadow model
// Drives on rising edges and samples responses and outputs on falling edges
`include "dcore_params.svh"

module digital_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 20;  // Cycles per wait

    logic                     clk;
    logic                     rst_n;
    dcore_pkg::wb_req_t       req;
    dcore_pkg::wb_rsp_t       rsp;
    logic [`DCORE_PAD_N-1:0]  io_in;
    logic [`DCORE_PAD_N-1:0]  io_out;
    logic [`DCORE_PAD_N-1:0]  io_oeb;
    dcore_pkg::rst_ctrl_t     rst_ctrl;
    dcore_pkg::sdr_cfg_t      sdr_cfg;
    logic                     soft_irq;
    logic [2:0]               user_irq;

    logic [31:0]              lfsr = 32'h924d_59d8;
    logic [31:0]              glbl_sh [4];  // Config words 0 to 3
    logic [`DCORE_PAD_N-1:0]  out_sh;
    logic [`DCORE_PAD_N-1:0]  oeb_sh;
    logic [`DCORE_PAD_N-1:0]  in_sh;        // Last io_in driven

    tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

    digital_core DUT (
        .wb_clk_i      (clk      ),
        .rst_n_i       (rst_n    ),
        .wbd_ext_req_i (req      ),
        .wbd_ext_rsp_o (rsp      ),
        .io_in_i       (io_in    ),
        .io_out_o      (io_out   ),
        .io_oeb_o      (io_oeb   ),
        .rst_ctrl_o    (rst_ctrl ),
        .sdr_cfg_o     (sdr_cfg  ),
        .soft_irq_o    (soft_irq ),
        .user_irq_o    (user_irq )
    );

    // ------------------------------
    // Random source and model
    // ------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};     // One step per bit
        end
    endtask

    function automatic logic [31:0] lane_merge(input logic [31:0] old, input logic [31:0] wdat,
                                               input logic [3:0] sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old & ~mask) | (wdat & mask);
    endfunction

    function automatic logic [31:0] glbl_mask(input logic [1:0] ofs);
        case (ofs)
            2'd0:    return 32'h0000_0007;  // Three resets
            2'd1:    return 32'h0000_000f;  // Soft plus user irq
            2'd2:    return 32'h0000_03ff;  // Mode fields
            default: return 32'h000f_ffff;  // Five timing nibbles
        endcase
    endfunction

    function automatic logic [31:0] exp_word(input logic [3:0] rgn, input logic [3:0] ofs);
        if (rgn == `DCORE_RGN_GLBL) begin
            if (ofs < 4) return glbl_sh[ofs[1:0]];
            return (ofs == 4) ? `DCORE_IDCODE : 32'h0;
        end else if (rgn == `DCORE_RGN_PAD) begin
            case (ofs)
                4'd0:    return out_sh[31:0];
                4'd1:    return 32'(out_sh[`DCORE_PAD_N-1:32]);  // Upper pads zero extended
                4'd2:    return oeb_sh[31:0];
                4'd3:    return 32'(oeb_sh[`DCORE_PAD_N-1:32]);
                4'd4:    return in_sh[31:0];
                4'd5:    return 32'(in_sh[`DCORE_PAD_N-1:32]);
                default: return 32'h0;
            endcase
        end
        return 32'h0;                      // Unmapped
    endfunction

    task automatic model_write(input logic [3:0] rgn, input logic [3:0] ofs,
                               input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] w;
        w = lane_merge(exp_word(rgn, ofs), dat, sel);
        if (rgn == `DCORE_RGN_GLBL && ofs < 4) begin
            glbl_sh[ofs[1:0]] = w & glbl_mask(ofs[1:0]);
        end else if (rgn == `DCORE_RGN_PAD) begin
            case (ofs)
                4'd0:    out_sh[31:0] = w;
                4'd1:    out_sh[`DCORE_PAD_N-1:32] = w[`DCORE_PAD_N-33:0];
                4'd2:    oeb_sh[31:0] = w;
                4'd3:    oeb_sh[`DCORE_PAD_N-1:32] = w[`DCORE_PAD_N-33:0];
                default: ;                 // Input words ignore writes
            endcase
        end
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic stop_fail();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_fail();
        end
    endtask

    task automatic check_outputs();
        check_val(rst_ctrl, {glbl_sh[0][0], glbl_sh[0][1], glbl_sh[0][2]}, "rst_ctrl_o");
        check_val(soft_irq, glbl_sh[1][0], "soft_irq_o");
        check_val(user_irq, glbl_sh[1][3:1], "user_irq_o");
        check_val(sdr_cfg, {glbl_sh[2][1:0], glbl_sh[2][3:2], glbl_sh[2][6:4],
                            glbl_sh[2][8:7], glbl_sh[2][9], glbl_sh[3][3:0], glbl_sh[3][7:4],
                            glbl_sh[3][11:8], glbl_sh[3][15:12], glbl_sh[3][19:16]},
                  "sdr_cfg_o");
        check_val(io_out, out_sh, "io_out_o");
        check_val(io_oeb, oeb_sh, "io_oeb_o");
    endtask

    // A bound assertion failure stops the run too
    always @(posedge clk) begin
        if (DUT.u_sva.fail_cnt != 0) begin
            $display("A bound assertion failed before %0t", $time);
            stop_fail();
        end
    end

    // ------------------------------
    // Bus tasks
    // ------------------------------
    task automatic bus_cycle(input logic we, input logic [3:0] rgn, input logic [3:0] ofs,
                             input logic [31:0] dat, input logic [3:0] sel,
                             output logic [31:0] rdat, output logic err);
        int  cnt;
        logic done;
        cnt  = 0;
        done = 1'b0;
        @(posedge clk);
        req <= '{stb: 1'b1, we: we, adr: {20'h0, rgn, 2'b0, ofs, 2'b0}, dat: dat, sel: sel};
        while (!done) begin
            @(negedge clk);
            if (rsp.ack || rsp.err) begin
                done = 1'b1;
                rdat = rsp.dat;
                err  = rsp.err;
                if (we) check_outputs();   // Outputs change with ack
            end else if (++cnt > TIMEOUT) begin
                $display("Timeout at %0t: no ack or err from the DUT", $time);
                stop_fail();
            end
        end
        @(posedge clk);
        req <= '0;                          // Drop stb for a cycle
    endtask

    task automatic bus_write(input logic [3:0] rgn, input logic [3:0] ofs,
                             input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] rdat;
        logic        err;
        model_write(rgn, ofs, dat, sel);
        bus_cycle(1'b1, rgn, ofs, dat, sel, rdat, err);
        check_val(err, rgn > `DCORE_RGN_PAD, "write err");
    endtask

    task automatic bus_read(input logic [3:0] rgn, input logic [3:0] ofs);
        logic [31:0] rdat;
        logic        err;
        bus_cycle(1'b0, rgn, ofs, 32'h0, 4'h0, rdat, err);
        check_val(err, rgn > `DCORE_RGN_PAD, "read err");
        check_val(rdat, exp_word(rgn, ofs), $sformatf("read rgn %0d ofs %0d", rgn, ofs));
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        int          cnt;
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] s;
        req    = '0;
        io_in  = '0;
        out_sh = `DCORE_PAD_OUT_RST;
        oeb_sh = `DCORE_PAD_OEB_RST;
        in_sh  = '0;
        for (int o = 0; o < 4; o++) glbl_sh[o] = '0;
        cnt = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            if (++cnt > TIMEOUT) begin
                $display("Timeout at %0t: reset never released", $time);
                stop_fail();
            end
        end

        // Reset values
        for (int o = 0; o < 6; o++) bus_read(`DCORE_RGN_GLBL, o);
        for (int o = 0; o < 4; o++) bus_read(`DCORE_RGN_PAD, o);
        check_outputs();

        // Config words with random byte enables and then the ID
        repeat (32) begin
            draw(2, r);
            draw(32, d);
            draw(4, s);
            bus_write(`DCORE_RGN_GLBL, r[3:0], d, s[3:0]);
            bus_read(`DCORE_RGN_GLBL, r[3:0]);
        end
        draw(32, d);
        bus_write(`DCORE_RGN_GLBL, 4'd4, d, 4'hf);
        bus_read(`DCORE_RGN_GLBL, 4'd4);

        // Pad words where offsets 4 to 7 are read only or holes
        repeat (32) begin
            draw(3, r);
            draw(32, d);
            draw(4, s);
            bus_write(`DCORE_RGN_PAD, r[3:0], d, s[3:0]);
            bus_read(`DCORE_RGN_PAD, r[3:0]);
        end
        bus_write(`DCORE_RGN_PAD, 4'd1, 32'hffff_ffea, 4'hf);  // Upper pad bits
        bus_write(`DCORE_RGN_PAD, 4'd3, 32'hffff_ff15, 4'hf);

        // io_in through the synchronizer
        repeat (4) begin
            draw(32, d);
            draw(6, r);
            @(posedge clk);
            io_in <= {r[5:0], d};
            in_sh  = {r[5:0], d};
            repeat (3) @(posedge clk);
            bus_read(`DCORE_RGN_PAD, 4'd4);
            bus_read(`DCORE_RGN_PAD, 4'd5);
        end

        // Unmapped regions answer err and change nothing
        repeat (8) begin
            draw(4, r);
            if (r[3:0] < 2) r = r + 2;
            draw(4, s);
            draw(32, d);
            bus_write(r[3:0], s[3:0], d, 4'hf);
            bus_read(r[3:0], s[3:0]);
        end
        for (int o = 0; o < 5; o++) bus_read(`DCORE_RGN_GLBL, o);
        for (int o = 0; o < 6; o++) bus_read(`DCORE_RGN_PAD, o);

        // Last assertion attempts finish before the verdict
        repeat (2) @(negedge clk);
        if (DUT.u_sva.fail_cnt != 0) begin
            $display("Bound assertions failed %0d times", DUT.u_sva.fail_cnt);
            stop_fail();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* digital_core_sva.sv */
// Bus handshake and pad reset assertions bound into the digital core top
// fail_cnt is polled by the testbench
`include "dcore_params.svh"

module digital_core_sva (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  dcore_pkg::wb_req_t       req_i,
    input  dcore_pkg::wb_rsp_t       rsp_i,
    input  logic [`DCORE_PAD_N-1:0]  io_oeb_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int   fail_cnt = 0;  // Read by the testbench
    logic rsp_any;

    assign rsp_any = rsp_i.ack | rsp_i.err;

    // ------------------------------
    // Handshake timing
    // ------------------------------
    // No response in the strobe cycle but one in the next
    a_rsp_one_cycle : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(req_i.stb) |-> !rsp_any ##1 rsp_any)
        else begin
            fail_cnt++;
            $error("No response exactly one cycle after stb");
        end

    a_rsp_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_any |=> !rsp_any)                        // Single cycle pulse
        else begin
            fail_cnt++;
            $error("Response held longer than one cycle");
        end

    a_rsp_needs_stb : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_any |-> $past(req_i.stb))
        else begin
            fail_cnt++;
            $error("Response without a preceding stb");
        end

    a_ack_err_excl : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rsp_i.ack && rsp_i.err))
        else begin
            fail_cnt++;
            $error("ack and err high together");
        end

    // Pads come out of reset as inputs
    a_oeb_reset : assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (io_oeb_i == {`DCORE_PAD_N{1'b1}}))
        else begin
            fail_cnt++;
            $error("io_oeb_o not all ones after reset");
        end

endmodule

bind digital_core digital_core_sva u_sva (
    .clk_i    (wb_clk_i      ),
    .rst_n_i  (rst_n_i       ),
    .req_i    (wbd_ext_req_i ),
    .rsp_i    (wbd_ext_rsp_o ),
    .io_oeb_i (io_oeb_o      )
);

/* tb_clkgen.sv */
// Testbench clock and reset source, 10 ns period
// Reset held low for the first two rising edges, released on a clock edge
module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 100 MHz
    end

    // Synchronous release after two cycles
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* digital_core.sv */
// Digital core top: external Wishbone master to the config and pad slaves
// SDRAM setup and block resets leave the chip for controllers outside
`include "dcore_params.svh"

module digital_core (
    input  logic                     wb_clk_i,       // System clock
    input  logic                     rst_n_i,        // Sync, active low

    // External Wishbone master
    input  dcore_pkg::wb_req_t       wbd_ext_req_i,
    output dcore_pkg::wb_rsp_t       wbd_ext_rsp_o,

    // IO pads
    input  logic [`DCORE_PAD_N-1:0]  io_in_i,
    output logic [`DCORE_PAD_N-1:0]  io_out_o,
    output logic [`DCORE_PAD_N-1:0]  io_oeb_o,

    // Configuration
    output dcore_pkg::rst_ctrl_t     rst_ctrl_o,
    output dcore_pkg::sdr_cfg_t      sdr_cfg_o,
    output logic                     soft_irq_o,
    output logic [2:0]               user_irq_o
);

    // ------------------------------
    // Slave side buses
    // ------------------------------
    dcore_pkg::wb_req_t glbl_req;   // To global config
    dcore_pkg::wb_rsp_t glbl_rsp;
    dcore_pkg::wb_req_t pad_req;    // To pad control
    dcore_pkg::wb_rsp_t pad_rsp;

    wb_intercon u_intercon (
        .wb_clk_i   (wb_clk_i      ),
        .rst_n_i    (rst_n_i       ),
        .m_req_i    (wbd_ext_req_i ),
        .m_rsp_o    (wbd_ext_rsp_o ),
        .glbl_req_o (glbl_req      ),
        .glbl_rsp_i (glbl_rsp      ),
        .pad_req_o  (pad_req       ),
        .pad_rsp_i  (pad_rsp       )
    );

    glbl_cfg u_glbl_cfg (
        .wb_clk_i   (wb_clk_i      ),
        .rst_n_i    (rst_n_i       ),
        .req_i      (glbl_req      ),
        .rsp_o      (glbl_rsp      ),
        .rst_ctrl_o (rst_ctrl_o    ),
        .soft_irq_o (soft_irq_o    ),
        .user_irq_o (user_irq_o    ),
        .sdr_cfg_o  (sdr_cfg_o     )
    );

    pad_ctrl u_pad_ctrl (
        .wb_clk_i   (wb_clk_i      ),
        .rst_n_i    (rst_n_i       ),
        .req_i      (pad_req       ),
        .rsp_o      (pad_rsp       ),
        .io_in_i    (io_in_i       ),
        .io_out_o   (io_out_o      ),
        .io_oeb_o   (io_oeb_o      )
    );

endmodule

/* pad_ctrl.sv */
// Pad control slave: io_out and io_oeb registers, synchronized io_in readback
// Pads split over a low word (31:0) and a high word (upper bits) per function
`include "dcore_params.svh"

module pad_ctrl (
    input  logic                     wb_clk_i,
    input  logic                     rst_n_i,

    // Register bus
    input  dcore_pkg::wb_req_t       req_i,
    output dcore_pkg::wb_rsp_t       rsp_o,

    // Pads
    input  logic [`DCORE_PAD_N-1:0]  io_in_i,
    output logic [`DCORE_PAD_N-1:0]  io_out_o,
    output logic [`DCORE_PAD_N-1:0]  io_oeb_o
);

    localparam int HI_W = `DCORE_PAD_N - 32;  // Pads in the high word

    logic [`DCORE_OFS_MSB-`DCORE_OFS_LSB:0] ofs;
    logic                                   acc;       // Accepting cycle
    logic                                   ack_q;
    logic [`DCORE_WB_DW-1:0]                cur_word;
    logic [`DCORE_WB_DW-1:0]                wr_word;
    logic [`DCORE_WB_DW-1:0]                rdat_q;

    logic [`DCORE_PAD_N-1:0]                out_q;
    logic [`DCORE_PAD_N-1:0]                oeb_q;     // 1 = input
    logic [`DCORE_PAD_N-1:0]                in_s1;     // First sync stage
    logic [`DCORE_PAD_N-1:0]                in_s2;     // Stable copy

    assign ofs = req_i.adr[`DCORE_OFS_MSB:`DCORE_OFS_LSB];
    assign acc = req_i.stb & ~ack_q;

    // ------------------------------
    // Input synchronizer
    // ------------------------------
    always_ff @(posedge wb_clk_i) begin
        in_s1 <= io_in_i;
        in_s2 <= in_s1;
    end

    // Read mux, upper words zero extended
    always_comb begin
        case (ofs)
            `DCORE_PAD_OUT_LO: cur_word = out_q[31:0];
            `DCORE_PAD_OUT_HI: cur_word = {{(32-HI_W){1'b0}}, out_q[`DCORE_PAD_N-1:32]};
            `DCORE_PAD_OEB_LO: cur_word = oeb_q[31:0];
            `DCORE_PAD_OEB_HI: cur_word = {{(32-HI_W){1'b0}}, oeb_q[`DCORE_PAD_N-1:32]};
            `DCORE_PAD_IN_LO:  cur_word = in_s2[31:0];
            `DCORE_PAD_IN_HI:  cur_word = {{(32-HI_W){1'b0}}, in_s2[`DCORE_PAD_N-1:32]};
            default:           cur_word = '0;
        endcase
    end

    assign wr_word = dcore_pkg::be_merge(cur_word, req_i.dat, req_i.sel);

    // ------------------------------
    // Pad registers and ack
    // ------------------------------
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            out_q <= `DCORE_PAD_OUT_RST;
            oeb_q <= `DCORE_PAD_OEB_RST;  // Pads start as inputs
        end else begin
            ack_q <= acc;
            if (acc && req_i.we) begin
                case (ofs)
                    `DCORE_PAD_OUT_LO: out_q[31:0]              <= wr_word;
                    `DCORE_PAD_OUT_HI: out_q[`DCORE_PAD_N-1:32] <= wr_word[HI_W-1:0];
                    `DCORE_PAD_OEB_LO: oeb_q[31:0]              <= wr_word;
                    `DCORE_PAD_OEB_HI: oeb_q[`DCORE_PAD_N-1:32] <= wr_word[HI_W-1:0];
                    default: ;  // Input words are read only
                endcase
            end
        end
    end

    // Readback captured at accept
    always_ff @(posedge wb_clk_i) begin
        if (acc) rdat_q <= cur_word;
    end

    assign rsp_o    = '{dat: rdat_q, ack: ack_q, err: 1'b0};
    assign io_out_o = out_q;
    assign io_oeb_o = oeb_q;

endmodule

/* glbl_cfg.sv */
// Global configuration register bank: block resets, interrupts, SDRAM setup
// Wishbone slave, one cycle ack, byte enable writes, read-only device ID
`include "dcore_params.svh"

module glbl_cfg (
    input  logic                   wb_clk_i,
    input  logic                   rst_n_i,

    // Register bus
    input  dcore_pkg::wb_req_t     req_i,
    output dcore_pkg::wb_rsp_t     rsp_o,

    // Configuration outputs
    output dcore_pkg::rst_ctrl_t   rst_ctrl_o,
    output logic                   soft_irq_o,
    output logic [2:0]             user_irq_o,
    output dcore_pkg::sdr_cfg_t    sdr_cfg_o
);

    logic [`DCORE_OFS_MSB-`DCORE_OFS_LSB:0] ofs;       // Word offset
    logic                                   acc;       // Accepting cycle
    logic                                   ack_q;
    logic [`DCORE_WB_DW-1:0]                cur_word;  // Selected register
    logic [`DCORE_WB_DW-1:0]                wr_word;   // After byte merge
    logic [`DCORE_WB_DW-1:0]                rdat_q;

    // Register storage
    logic [2:0]  rst_q;    // sdram, spi, cpu
    logic [3:0]  irq_q;    // user[2:0], soft
    logic [9:0]  sdrm_q;   // en, req_depth, cas, colbits, width
    logic [19:0] sdrt_q;   // twr, trcar, trcd, trp, tras

    assign ofs = req_i.adr[`DCORE_OFS_MSB:`DCORE_OFS_LSB];
    assign acc = req_i.stb & ~ack_q;  // Held strobe ignored during ack

    // ------------------------------
    // Read mux, also write base
    // ------------------------------
    always_comb begin
        case (ofs)
            `DCORE_GLBL_RST:  cur_word = {29'b0, rst_q};
            `DCORE_GLBL_IRQ:  cur_word = {28'b0, irq_q};
            `DCORE_GLBL_SDRM: cur_word = {22'b0, sdrm_q};
            `DCORE_GLBL_SDRT: cur_word = {12'b0, sdrt_q};
            `DCORE_GLBL_ID:   cur_word = `DCORE_IDCODE;
            default:          cur_word = '0;  // Holes read zero
        endcase
    end

    assign wr_word = dcore_pkg::be_merge(cur_word, req_i.dat, req_i.sel);

    // Control registers and ack
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q  <= 1'b0;
            rst_q  <= '0;   // All blocks held in reset
            irq_q  <= '0;
            sdrm_q <= '0;   // SDRAM disabled
            sdrt_q <= '0;
        end else begin
            ack_q <= acc;
            if (acc && req_i.we) begin
                case (ofs)
                    `DCORE_GLBL_RST:  rst_q  <= wr_word[2:0];
                    `DCORE_GLBL_IRQ:  irq_q  <= wr_word[3:0];
                    `DCORE_GLBL_SDRM: sdrm_q <= wr_word[9:0];
                    `DCORE_GLBL_SDRT: sdrt_q <= wr_word[19:0];
                    default: ;                 // ID and holes ignore writes
                endcase
            end
        end
    end

    // Read data lands with ack
    always_ff @(posedge wb_clk_i) begin
        if (acc) rdat_q <= cur_word;
    end

    assign rsp_o = '{dat: rdat_q, ack: ack_q, err: 1'b0};

    // ------------------------------
    // Field mapping to outputs
    // ------------------------------
    assign rst_ctrl_o = '{cpu_rst_n:   rst_q[0],
                          spi_rst_n:   rst_q[1],
                          sdram_rst_n: rst_q[2]};
    assign soft_irq_o = irq_q[0];
    assign user_irq_o = irq_q[3:1];

    // Mode word packs from bit 0 in struct order
    assign sdr_cfg_o = '{width:     sdrm_q[1:0],
                         colbits:   sdrm_q[3:2],
                         cas:       sdrm_q[6:4],
                         req_depth: sdrm_q[8:7],
                         en:        sdrm_q[9],
                         tras:      sdrt_q[3:0],
                         trp:       sdrt_q[7:4],
                         trcd:      sdrt_q[11:8],
                         trcar:     sdrt_q[15:12],
                         twr:       sdrt_q[19:16]};

endmodule

/* wb_intercon.sv */
// Single master Wishbone interconnect for the config and pad slaves
// Region decode on the address, response merge and err for unmapped regions
`include "dcore_params.svh"

module wb_intercon (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    // External master
    input  dcore_pkg::wb_req_t   m_req_i,
    output dcore_pkg::wb_rsp_t   m_rsp_o,

    // Global config slave
    output dcore_pkg::wb_req_t   glbl_req_o,
    input  dcore_pkg::wb_rsp_t   glbl_rsp_i,

    // Pad control slave
    output dcore_pkg::wb_req_t   pad_req_o,
    input  dcore_pkg::wb_rsp_t   pad_rsp_i
);

    logic [`DCORE_RGN_MSB-`DCORE_RGN_LSB:0] rgn;   // Region code
    logic                                   hit_glbl;
    logic                                   hit_pad;
    logic                                   miss;     // Unmapped access
    logic                                   err_q;    // Error pulse

    // ------------------------------
    // Region decode
    // ------------------------------
    assign rgn      = m_req_i.adr[`DCORE_RGN_MSB:`DCORE_RGN_LSB];
    assign hit_glbl = (rgn == `DCORE_RGN_GLBL);
    assign hit_pad  = (rgn == `DCORE_RGN_PAD);
    assign miss     = m_req_i.stb & ~hit_glbl & ~hit_pad;

    // Fields go to both, strobe only to the hit slave
    always_comb begin
        glbl_req_o     = m_req_i;
        glbl_req_o.stb = m_req_i.stb & hit_glbl;
        pad_req_o      = m_req_i;
        pad_req_o.stb  = m_req_i.stb & hit_pad;
    end

    // One cycle err, same latency as a slave ack
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= miss & ~err_q;  // No repeat while master still holds stb
        end
    end

    // ------------------------------
    // Response merge
    // ------------------------------
    always_comb begin
        m_rsp_o.ack = glbl_rsp_i.ack | pad_rsp_i.ack;
        m_rsp_o.err = err_q | glbl_rsp_i.err | pad_rsp_i.err;
        // Data from whichever slave acks, zero otherwise
        if (glbl_rsp_i.ack) begin
            m_rsp_o.dat = glbl_rsp_i.dat;
        end else if (pad_rsp_i.ack) begin
            m_rsp_o.dat = pad_rsp_i.dat;
        end else begin
            m_rsp_o.dat = '0;  // Also the err case
        end
    end

endmodule

/* dcore_pkg.sv */
// Bus request/response and configuration bundle types for the digital core
// Referenced by scoped name from the interconnect, the slaves and the top
`include "dcore_params.svh"

package dcore_pkg;

    // ------------------------------
    // Wishbone bundles
    // ------------------------------

    // One master request, cyc and stb folded into stb
    typedef struct packed {
        logic                      stb;   // Cycle plus strobe
        logic                      we;    // 1 write, 0 read
        logic [`DCORE_WB_AW-1:0]   adr;
        logic [`DCORE_WB_DW-1:0]   dat;   // Write data
        logic [`DCORE_WB_SW-1:0]   sel;   // Byte enables
    } wb_req_t;

    // Slave response
    typedef struct packed {
        logic [`DCORE_WB_DW-1:0]   dat;   // Read data, valid with ack
        logic                      ack;
        logic                      err;
    } wb_rsp_t;

    // ------------------------------
    // Configuration outputs
    // ------------------------------

    // Active low block resets
    typedef struct packed {
        logic       cpu_rst_n;
        logic       spi_rst_n;
        logic       sdram_rst_n;
    } rst_ctrl_t;

    // SDRAM controller setup
    typedef struct packed {
        logic [1:0] width;      // 00 32b, 01 16b, 1x 8b
        logic [1:0] colbits;    // Column address bits
        logic [2:0] cas;        // CAS latency
        logic [1:0] req_depth;  // Max queued requests
        logic       en;         // Controller enable
        logic [3:0] tras;       // Active to precharge
        logic [3:0] trp;        // Precharge to active
        logic [3:0] trcd;       // Active to read/write
        logic [3:0] trcar;      // Auto refresh period
        logic [3:0] twr;        // Write recovery
    } sdr_cfg_t;

    // Byte lane merge for register writes
    function automatic logic [`DCORE_WB_DW-1:0] be_merge(
        input logic [`DCORE_WB_DW-1:0] cur,
        input logic [`DCORE_WB_DW-1:0] wdat,
        input logic [`DCORE_WB_SW-1:0] sel
    );
        logic [`DCORE_WB_DW-1:0] res;
        res = cur;
        for (int b = 0; b < `DCORE_WB_SW; b++) begin
            if (sel[b]) res[8*b +: 8] = wdat[8*b +: 8];  // Take enabled lane
        end
        return res;
    endfunction

endpackage

/* dcore_params.svh */
// Shared widths, address decode fields, register offsets and reset values
// Include in any file that needs bus widths or register map codes
`ifndef DCORE_PARAMS_SVH
`define DCORE_PARAMS_SVH

// Bus widths ------------------------
`define DCORE_WB_AW      32                 // Address width
`define DCORE_WB_DW      32                 // Data width
`define DCORE_WB_SW      4                  // Byte enables

// Address decode ------------------------
`define DCORE_RGN_MSB    11                 // Region select field
`define DCORE_RGN_LSB    8
`define DCORE_RGN_GLBL   4'h0               // Global config block
`define DCORE_RGN_PAD    4'h1               // Pad control block
`define DCORE_OFS_MSB    5                  // Word offset in a region
`define DCORE_OFS_LSB    2

// Global config offsets
`define DCORE_GLBL_RST   4'd0               // Block resets
`define DCORE_GLBL_IRQ   4'd1               // Soft and user irq
`define DCORE_GLBL_SDRM  4'd2               // SDRAM mode fields
`define DCORE_GLBL_SDRT  4'd3               // SDRAM timing nibbles
`define DCORE_GLBL_ID    4'd4               // Device ID, read only

// Pad control offsets
`define DCORE_PAD_OUT_LO 4'd0
`define DCORE_PAD_OUT_HI 4'd1
`define DCORE_PAD_OEB_LO 4'd2
`define DCORE_PAD_OEB_HI 4'd3
`define DCORE_PAD_IN_LO  4'd4
`define DCORE_PAD_IN_HI  4'd5

// Pads and constants
`define DCORE_PAD_N       38
`define DCORE_IDCODE      32'hdc03_0a01
`define DCORE_PAD_OUT_RST {`DCORE_PAD_N{1'b0}}  // Drive low
`define DCORE_PAD_OEB_RST {`DCORE_PAD_N{1'b1}}  // All pads input

`endif
